// ==== all.f ====
+incdir+source
source/spm_pkg.sv
source/spm_mem_if.sv
source/spm_sram_bank.sv
source/spm_bank_array.sv
source/spm_req_frontend.sv
source/spm_tile.sv
bench/spm_tile_tb.sv

// ==== bench/spm_tile_stimulus.txt ====
# op addr wdata strb err rdata, all hex after op, rdata checked only on reads without error
# W/R wait 0 to 3 random idle cycles first, w/r follow the previous request directly
W 00010010 11111111 f 0 00000000
W 00010410 22222222 f 0 00000000
W 00010810 33333333 f 0 00000000
W 00010c10 44444444 f 0 00000000
R 00010010 00000000 0 0 11111111
R 00010410 00000000 0 0 22222222
R 00010810 00000000 0 0 33333333
R 00010c10 00000000 0 0 44444444
W 00010000 deadbeef f 0 00000000
W 00010ffc a5a5a5a5 f 0 00000000
R 00010000 00000000 0 0 deadbeef
R 00010ffc 00000000 0 0 a5a5a5a5
W 00010020 aabbccdd f 0 00000000
W 00010020 11223344 1 0 00000000
R 00010020 00000000 0 0 aabbcc44
W 00010020 55667788 6 0 00000000
R 00010020 00000000 0 0 aa667744
W 00010420 cafef00d f 0 00000000
W 00010420 12345678 8 0 00000000
W 00010420 ffffffff 0 0 00000000
R 00010420 00000000 0 0 12fef00d
W 0000fffc 99999999 f 1 00000000
W 00011000 99999999 f 1 00000000
W 00010012 99999999 f 1 00000000
R 00010011 00000000 0 1 00000000
R 20010000 00000000 0 1 00000000
R 00010010 00000000 0 0 11111111
R 00010ffc 00000000 0 0 a5a5a5a5
R 00010000 00000000 0 0 deadbeef
W 00010040 01020304 f 0 00000000
r 00010040 00000000 0 0 01020304
w 00010040 0a0b0c0d 3 0 00000000
r 00010040 00000000 0 0 01020c0d
w 00010840 fedcba98 f 0 00000000
w 00011000 77777777 f 1 00000000
r 00010840 00000000 0 0 fedcba98
r 00010040 00000000 0 0 01020c0d
r 00010000 00000000 0 0 deadbeef

// ==== bench/spm_tile_tb.sv ====
////////////////////////////////////////
// Testbench for the scratchpad tile
// Must run from the project root, the
// stimulus file path is relative to it
////////////////////////////////////////

`timescale 1ns/10ps

module spm_tile_tb
  import spm_pkg::*;
();

  localparam int unsigned CLK_PERIOD = 40;
  localparam int unsigned RSP_DELAY  = 2;

  logic          clk_i;
  logic          rst_n_i;
  logic          req_valid_i;
  logic          req_we_i;
  spm_bus_addr_t req_addr_i;
  spm_data_t     req_wdata_i;
  spm_strb_t     req_strb_i;
  logic          rsp_valid_o;
  logic          rsp_err_o;
  spm_data_t     rsp_rdata_o;

  // Requests read from the stimulus file
  logic          stim_we    [$];
  logic          stim_b2b   [$];
  spm_bus_addr_t stim_addr  [$];
  spm_data_t     stim_wdata [$];
  spm_strb_t     stim_strb  [$];
  logic          stim_err   [$];
  spm_data_t     stim_rdata [$];

  // Outstanding responses, oldest first
  logic          exp_we_q    [$];
  logic          exp_err_q   [$];
  spm_data_t     exp_rdata_q [$];
  int unsigned   exp_edge_q  [$];

  int unsigned   edge_cnt = 0;
  logic [31:0]   lfsr_state;
  logic          loaded;
  logic          rst_done;

  logic          mon_we;
  logic          mon_err;
  spm_data_t     mon_rdata;
  int unsigned   mon_edge;

  spm_tile uut (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_we_i    (req_we_i),
    .req_addr_i  (req_addr_i),
    .req_wdata_i (req_wdata_i),
    .req_strb_i  (req_strb_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_err_o   (rsp_err_o),
    .rsp_rdata_o (rsp_rdata_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    edge_cnt <= edge_cnt + 1;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_err(input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("FAILED at %0d ns: rsp_err_o is %b, expected %b",
                                  $time, got, exp));
    end
  endtask

  task automatic check_data(input spm_data_t got, input spm_data_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("FAILED at %0d ns: rsp_rdata_o is %h, expected %h",
                                  $time, got, exp));
    end
  endtask

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_gap(output int unsigned gap);
    gap = 0;
    for (int b = 0; b < 2; b++) begin
      gap = (gap << 1) | lfsr_state[31];
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  task automatic load_stimulus();
    int            fd;
    int            c;
    int            n;
    spm_bus_addr_t addr;
    spm_data_t     wdata;
    spm_strb_t     strb;
    logic          err;
    spm_data_t     rdata;
    fd = $fopen("bench/spm_tile_stimulus.txt", "r");
    if (fd == 0) begin
      stop_with_failure("Could not open bench/spm_tile_stimulus.txt");
    end else begin
      c = $fgetc(fd);
      while (c != -1) begin
        if (c == "#") begin
          // Comment runs to the end of the line
          while (c != -1 && c != "\n") begin
            c = $fgetc(fd);
          end
        end else if (c == "W" || c == "R" || c == "w" || c == "r") begin
          n = $fscanf(fd, "%h %h %h %h %h", addr, wdata, strb, err, rdata);
          if (n != 5) begin
            stop_with_failure("A stimulus line has fewer than six columns");
          end else begin
            stim_we.push_back(c == "W" || c == "w");
            stim_b2b.push_back(c == "w" || c == "r");
            stim_addr.push_back(addr);
            stim_wdata.push_back(wdata);
            stim_strb.push_back(strb);
            stim_err.push_back(err);
            stim_rdata.push_back(rdata);
          end
        end
        c = $fgetc(fd);
      end
      $fclose(fd);
    end
  endtask

  task automatic drive_request(input int idx);
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_we_i    <= stim_we[idx];
    req_addr_i  <= stim_addr[idx];
    req_wdata_i <= stim_wdata[idx];
    req_strb_i  <= stim_strb[idx];
    exp_we_q.push_back(stim_we[idx]);
    exp_err_q.push_back(stim_err[idx]);
    exp_rdata_q.push_back(stim_rdata[idx]);
    // Count of the edge that drives the request
    exp_edge_q.push_back(edge_cnt + 1);
  endtask

  ////////////////////////////////////////
  // Response monitor
  ////////////////////////////////////////

  always @(negedge clk_i) begin
    if (rst_done && $isunknown(rsp_valid_o)) begin
      stop_with_failure("rsp_valid_o is unknown after reset");
    end else if (rsp_valid_o === 1'b1) begin
      if (exp_err_q.size() == 0) begin
        stop_with_failure("A response arrived with no request outstanding");
      end else begin
        mon_we    = exp_we_q.pop_front();
        mon_err   = exp_err_q.pop_front();
        mon_rdata = exp_rdata_q.pop_front();
        mon_edge  = exp_edge_q.pop_front();
        if (edge_cnt != mon_edge + RSP_DELAY) begin
          stop_with_failure($sformatf(
            "Response at %0d ns came %0d edges after its request instead of %0d",
            $time, edge_cnt - mon_edge, RSP_DELAY));
        end else begin
          check_err(rsp_err_o, mon_err);
          if (!mon_we && !mon_err) begin
            check_data(rsp_rdata_o, mon_rdata);
          end
        end
      end
    end
  end

  initial begin : watchdog
    wait (loaded);
    #((stim_we.size() * 6 + 20) * CLK_PERIOD);
    stop_with_failure("Timeout, the run took longer than the stimulus allows");
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin : main
    int unsigned gap;
    int unsigned drain;
    rst_n_i     = 1'b0;
    req_valid_i = 1'b0;
    req_we_i    = 1'b0;
    req_addr_i  = '0;
    req_wdata_i = '0;
    req_strb_i  = '0;
    lfsr_state  = 32'h6c7e_1410;
    rst_done    = 1'b0;
    loaded      = 1'b0;
    load_stimulus();
    loaded = 1'b1;
    repeat (2) @(posedge clk_i);
    rst_n_i  <= 1'b1;
    rst_done <= 1'b1;
    // Quiet period, the monitor flags any early response
    repeat (3) @(posedge clk_i);
    for (int i = 0; i < stim_we.size(); i++) begin
      if (!stim_b2b[i]) begin
        random_gap(gap);
        repeat (gap) begin
          @(posedge clk_i);
          req_valid_i <= 1'b0;
        end
      end
      drive_request(i);
    end
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    drain = 0;
    while (exp_err_q.size() != 0 && drain < 10) begin
      @(posedge clk_i);
      drain++;
    end
    // A few more cycles to catch stray responses
    repeat (4) @(posedge clk_i);
    if (exp_err_q.size() != 0) begin
      stop_with_failure($sformatf("%0d expected responses never arrived",
                                  exp_err_q.size()));
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

// ==== source/spm_tile.sv ====
////////////////////////////////////////
// Scratchpad memory tile, top level
// Strobe handshake, one response per request
// Response two cycles after the request
////////////////////////////////////////

`timescale 1ns/10ps

module spm_tile
  import spm_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_n_i,
  // Request port
  input  logic          req_valid_i,
  input  logic          req_we_i,
  input  spm_bus_addr_t req_addr_i,
  input  spm_data_t     req_wdata_i,
  input  spm_strb_t     req_strb_i,
  // Response port
  output logic          rsp_valid_o,
  output logic          rsp_err_o,
  output spm_data_t     rsp_rdata_o
);

  ////////////////////////////////////////
  // Internal access bus
  ////////////////////////////////////////

  spm_mem_if mem_if ();

  ////////////////////////////////////////
  // Front end
  ////////////////////////////////////////

  spm_req_frontend i_frontend (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_we_i    (req_we_i),
    .req_addr_i  (req_addr_i),
    .req_wdata_i (req_wdata_i),
    .req_strb_i  (req_strb_i),
    .mem         (mem_if.requester),
    .rsp_valid_o (rsp_valid_o),
    .rsp_err_o   (rsp_err_o),
    .rsp_rdata_o (rsp_rdata_o)
  );

  ////////////////////////////////////////
  // Bank rows
  ////////////////////////////////////////

  spm_bank_array i_banks (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .mem     (mem_if.memory)
  );

endmodule

// ==== source/spm_req_frontend.sv ====
////////////////////////////////////////
// Request cut, address check and response
// Fixed latency of two cycles, no back-pressure
// Misaligned or out of window requests get an error
////////////////////////////////////////

`timescale 1ns/10ps
`include "spm_settings.svh"

module spm_req_frontend
  import spm_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_n_i,
  // Request port
  input  logic             req_valid_i,
  input  logic             req_we_i,
  input  spm_bus_addr_t    req_addr_i,
  input  spm_data_t        req_wdata_i,
  input  spm_strb_t        req_strb_i,
  // Access towards the bank array
  spm_mem_if.requester     mem,
  // Response port
  output logic             rsp_valid_o,
  output logic             rsp_err_o,
  output spm_data_t        rsp_rdata_o
);

  localparam int unsigned BYTE_OFS_W = $clog2(`SPM_DATA_WIDTH / 8);
  localparam int unsigned WORD_IDX_W = $bits(spm_word_idx_t);
  localparam int unsigned ROW_SEL_W  = $bits(spm_row_sel_t);
  localparam int unsigned ROW_OFS    = BYTE_OFS_W + WORD_IDX_W;
  localparam spm_bus_addr_t TILE_BYTES =
    spm_bus_addr_t'(`SPM_WORDS_PER_BANK * `SPM_NUM_BANK_ROWS * (`SPM_DATA_WIDTH / 8));

  spm_bus_addr_t req_ofs;
  logic          in_window;
  logic          aligned;
  logic          dec_err;

  logic          valid_q;
  logic          err_q;
  logic          we_q;
  spm_data_t     wdata_q;
  spm_strb_t     strb_q;
  spm_word_idx_t word_idx_q;
  spm_row_sel_t  row_sel_q;

  logic          rsp_valid_q;
  logic          rsp_err_q;

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////

  // Offset from the window base
  assign req_ofs   = req_addr_i - spm_bus_addr_t'(`SPM_BASE_ADDR);
  assign in_window = (req_addr_i >= spm_bus_addr_t'(`SPM_BASE_ADDR)) && (req_ofs < TILE_BYTES);
  assign aligned   = (req_addr_i[BYTE_OFS_W-1:0] == '0);
  assign dec_err   = !(in_window && aligned);

  ////////////////////////////////////////
  // Request cut
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      valid_q <= req_valid_i;
      err_q   <= req_valid_i && dec_err;
    end
  end

  // Request payload for the access stage
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      we_q       <= req_we_i;
      wdata_q    <= req_wdata_i;
      strb_q     <= req_strb_i;
      word_idx_q <= req_ofs[BYTE_OFS_W +: WORD_IDX_W];
      row_sel_q  <= req_ofs[ROW_OFS +: ROW_SEL_W];
    end
  end

  // Erroring requests never reach the SRAM
  assign mem.access   = valid_q && !err_q;
  assign mem.write    = we_q;
  assign mem.word_idx = word_idx_q;
  assign mem.row_sel  = row_sel_q;
  assign mem.wdata    = wdata_q;
  assign mem.strb     = strb_q;

  ////////////////////////////////////////
  // Response stage
  ////////////////////////////////////////

  // Lines up with the read data coming back from the banks
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
      rsp_err_q   <= 1'b0;
    end else begin
      rsp_valid_q <= valid_q;
      rsp_err_q   <= err_q;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_err_o   = rsp_err_q;
  assign rsp_rdata_o = mem.rdata;

endmodule

// ==== source/spm_bank_array.sv ====
////////////////////////////////////////
// Bank rows of the scratchpad
// Exactly one row is accessed per cycle
// Read data follows the access by one cycle
////////////////////////////////////////

`timescale 1ns/10ps
`include "spm_settings.svh"

module spm_bank_array
  import spm_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,
  // Access from the front end
  spm_mem_if.memory    mem
);

  localparam int unsigned NUM_ROWS = `SPM_NUM_BANK_ROWS;

  logic [NUM_ROWS-1:0] row_req;
  spm_data_t           row_rdata [NUM_ROWS];
  spm_row_sel_t        row_sel_q;

  ////////////////////////////////////////
  // Row select
  ////////////////////////////////////////

  // Remember which row answers in the next cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      row_sel_q <= '0;
    end else if (mem.access) begin
      row_sel_q <= mem.row_sel;
    end
  end

  ////////////////////////////////////////
  // SRAM rows
  ////////////////////////////////////////

  for (genvar r = 0; r < NUM_ROWS; r++) begin : gen_row
    // Only the addressed row sees the strobe
    assign row_req[r] = mem.access && (mem.row_sel == spm_row_sel_t'(r));

    spm_sram_bank i_bank (
      .clk_i   (clk_i),
      .req_i   (row_req[r]),
      .we_i    (mem.write),
      .addr_i  (mem.word_idx),
      .wdata_i (mem.wdata),
      .be_i    (mem.strb),
      .rdata_o (row_rdata[r])
    );
  end

  ////////////////////////////////////////
  // Read data return
  ////////////////////////////////////////

  // Data of the row that served the last access
  assign mem.rdata = row_rdata[row_sel_q];

endmodule

// ==== source/spm_sram_bank.sv ====
////////////////////////////////////////
// Behavioral single-port SRAM
// Byte-enabled write, one-cycle read latency
// Contents and read data come up undefined
////////////////////////////////////////

`timescale 1ns/10ps
`include "spm_settings.svh"

module spm_sram_bank
  import spm_pkg::*;
(
  input  logic          clk_i,
  input  logic          req_i,
  input  logic          we_i,
  input  spm_word_idx_t addr_i,
  input  spm_data_t     wdata_i,
  input  spm_strb_t     be_i,
  output spm_data_t     rdata_o
);

  localparam int unsigned NUM_BYTES = `SPM_DATA_WIDTH / 8;

  spm_data_t mem_q [`SPM_WORDS_PER_BANK];
  spm_data_t rdata_q;

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        // Only enabled bytes are updated
        for (int b = 0; b < NUM_BYTES; b++) begin
          if (be_i[b]) begin
            mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[addr_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

// ==== source/spm_mem_if.sv ====
////////////////////////////////////////
// One SRAM access from the front end
// Read data is valid one cycle after a read access
////////////////////////////////////////

`timescale 1ns/10ps

interface spm_mem_if
  import spm_pkg::*;
();

  // Access request, one-cycle strobe
  logic          access;
  logic          write;
  spm_word_idx_t word_idx;
  spm_row_sel_t  row_sel;
  spm_data_t     wdata;
  spm_strb_t     strb;

  // Returned read data
  spm_data_t     rdata;

  // Request side, drives the access
  modport requester (
    output access, write, word_idx, row_sel, wdata, strb,
    input  rdata
  );

  // Memory side, serves the access
  modport memory (
    input  access, write, word_idx, row_sel, wdata, strb,
    output rdata
  );

endinterface

// ==== source/spm_pkg.sv ====
////////////////////////////////////////
// Types shared by the scratchpad tile
// Widths follow the settings header
////////////////////////////////////////

`include "spm_settings.svh"

package spm_pkg;

  ////////////////////////////////////////
  // Port level types
  ////////////////////////////////////////

  // Byte address as seen on the tile port
  typedef logic [31:0] spm_bus_addr_t;

  // One data word
  typedef logic [`SPM_DATA_WIDTH-1:0] spm_data_t;

  // One strobe bit per data byte
  typedef logic [`SPM_DATA_WIDTH/8-1:0] spm_strb_t;

  ////////////////////////////////////////
  // Bank side types
  ////////////////////////////////////////

  // Word index inside one bank row
  typedef logic [$clog2(`SPM_WORDS_PER_BANK)-1:0] spm_word_idx_t;

  // Bank row number
  typedef logic [$clog2(`SPM_NUM_BANK_ROWS)-1:0] spm_row_sel_t;

endpackage

// ==== source/spm_settings.svh ====
////////////////////////////////////////
// Sizes of the scratchpad tile
// One bank per word, rows are selected by address
// Derived widths in the package assume powers of two
////////////////////////////////////////

`ifndef SPM_SETTINGS_SVH
`define SPM_SETTINGS_SVH

////////////////////////////////////////
// Word and bank geometry
////////////////////////////////////////

// Width of one data word in bits
`define SPM_DATA_WIDTH 32

// Depth of each SRAM bank row in words
`define SPM_WORDS_PER_BANK 256

// Number of bank rows stacked in the address map
`define SPM_NUM_BANK_ROWS 4

////////////////////////////////////////
// Address map
////////////////////////////////////////

// First byte address of the tile window
`define SPM_BASE_ADDR 32'h0001_0000

`endif
